// File: dv/hyper_ctrl_input.txt
# group client write addr burst base, all hex
# burst 0 means 64 words, lines of one group run on both clients at once
1 0 1 000100 04 1000
2 0 0 000100 04 0000
3 1 1 000200 01 2000
4 1 0 000200 01 0000
5 0 1 001000 00 3000
6 1 0 001000 00 0000
7 0 1 000400 08 4000
7 1 1 000500 08 5000
8 0 0 000500 08 0000
8 1 0 000400 08 0000
9 1 1 abcde5 03 6000
a 0 0 abcde5 03 0000
b 0 1 000010 10 7000
b 1 0 001020 05 0000
c 1 0 000010 10 0000
d 0 0 001030 02 0000
d 1 0 000404 04 0000
e 1 1 fffffe 02 8000
f 0 0 fffffe 02 0000

// File: vlog.f
hdl/hyper_pkg.sv
hdl/hyper_arbiter.sv
hdl/hyper_phy.sv
hdl/hyper_ctrl_top.sv
dv/hyper_ram_model.sv
dv/tb_clkgen.sv
dv/tb_hyper_ctrl.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps
TOP       = tb_hyper_ctrl
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_hyper_ctrl.sv
// Testbench top, runs the transaction list on both client ports against the HyperRAM model
`default_nettype none

module tb_hyper_ctrl;
  timeunit 1ns;
  timeprecision 100ps;
  import hyper_pkg::*;

  localparam int    CLK_NS     = 4;
  // Worst case cycles for one transaction of 64 words
  localparam int    TXN_CYCLES = 40 + 2 * 64;
  localparam string INPUT_FILE = "dv/hyper_ctrl_input.txt";

  logic clk;
  logic arst_n;

  logic        [NUM_CLIENTS-1:0] req;
  hyper_cmd_t  [NUM_CLIENTS-1:0] cmd;
  logic        [NUM_CLIENTS-1:0] ack;
  hyper_word_t [NUM_CLIENTS-1:0] wdata;
  logic        [NUM_CLIENTS-1:0] wdata_take;
  hyper_word_t [NUM_CLIENTS-1:0] rdata;
  logic        [NUM_CLIENTS-1:0] rdata_valid;

  logic            cs_n;
  logic            ck;
  logic            ck_n;
  logic            rwds_out;
  logic            rwds_oe;
  logic [DQ_W-1:0] dq_out;
  logic            dq_oe;
  logic            dev_reset_n;
  wire  [DQ_W-1:0] dq_bus;
  wire             rwds_bus;

  logic              model_ca_write;
  logic [ADDR_W-1:0] model_ca_addr;
  int                model_err_cnt;

  // Transaction list
  int          t_group[$];
  int          t_client[$];
  logic        t_write[$];
  logic [ADDR_W-1:0]  t_addr[$];
  logic [BURST_W-1:0] t_burst[$];
  hyper_word_t t_base[$];

  hyper_word_t ref_mem [int];
  int          order_q[$];
  int          last_served;
  int          err_cnt;
  int          mon_err_cnt;
  bit          list_loaded;
  logic [NUM_CLIENTS-1:0] ack_prev;

  assign dq_bus   = dq_oe ? dq_out : 'z;
  assign rwds_bus = rwds_oe ? rwds_out : 1'bz;

  tb_clkgen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(8)) i_clkgen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  hyper_ctrl_top i_dut (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .req_i           (req),
    .cmd_i           (cmd),
    .ack_o           (ack),
    .wdata_i         (wdata),
    .wdata_take_o    (wdata_take),
    .rdata_o         (rdata),
    .rdata_valid_o   (rdata_valid),
    .hyper_cs_n_o    (cs_n),
    .hyper_ck_o      (ck),
    .hyper_ck_n_o    (ck_n),
    .hyper_rwds_o    (rwds_out),
    .hyper_rwds_oe_o (rwds_oe),
    .hyper_rwds_i    (rwds_bus),
    .hyper_dq_o      (dq_out),
    .hyper_dq_oe_o   (dq_oe),
    .hyper_dq_i      (dq_bus),
    .hyper_reset_n_o (dev_reset_n)
  );

  hyper_ram_model i_ram (
    .clk_i      (clk),
    .reset_n_i  (dev_reset_n),
    .cs_n_i     (cs_n),
    .dq_io      (dq_bus),
    .rwds_i     (rwds_bus),
    .dq_oe_i    (dq_oe),
    .rwds_oe_i  (rwds_oe),
    .ca_write_o (model_ca_write),
    .ca_addr_o  (model_ca_addr),
    .err_cnt_o  (model_err_cnt)
  );

  // Lines that do not hold six hex fields are comments
  task automatic load_list;
    int    fd;
    int    n;
    string line;
    int    g;
    int    c;
    int    w;
    int    a;
    int    b;
    int    v;
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      err_cnt++;
      $display("could not open the transaction list %s", INPUT_FILE);
      return;
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%h %h %h %h %h %h", g, c, w, a, b, v);
      if (n == 6) begin
        t_group.push_back(g);
        t_client.push_back(c);
        t_write.push_back(w[0]);
        t_addr.push_back(ADDR_W'(a));
        t_burst.push_back(BURST_W'(b));
        t_base.push_back(hyper_word_t'(v));
      end
    end
    $fclose(fd);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_cnt++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_idle_pins;
    check_bit("ack_o", |ack, 1'b0);
    check_bit("wdata_take_o", |wdata_take, 1'b0);
    check_bit("rdata_valid_o", |rdata_valid, 1'b0);
    check_bit("hyper_cs_n_o", cs_n, 1'b1);
    check_bit("hyper_ck_o", ck, 1'b0);
    check_bit("hyper_ck_n_o", ck_n, 1'b1);
    check_bit("hyper_dq_oe_o", dq_oe, 1'b0);
    check_bit("hyper_rwds_oe_o", rwds_oe, 1'b0);
  endtask

  // One burst on client c, from request to the fall of its ack
  task automatic run_txn(input int c, input int t);
    int                words;
    int                takes;
    int                valids;
    bit                acked;
    logic [ADDR_W-1:0] a;
    words  = (t_burst[t] == 0) ? 64 : int'(t_burst[t]);
    takes  = 0;
    valids = 0;
    acked  = 1'b0;
    @(posedge clk);
    req[c]   <= 1'b1;
    cmd[c]   <= '{write: t_write[t], addr: t_addr[t], burst: t_burst[t]};
    wdata[c] <= t_base[t];
    while (!acked) begin
      @(posedge clk);
      if (wdata_take[c]) begin
        takes++;
        wdata[c] <= t_base[t] + hyper_word_t'(takes);
      end
      if (rdata_valid[c]) begin
        a = t_addr[t] + ADDR_W'(valids);
        if (!ref_mem.exists(int'(a))) begin
          err_cnt++;
          $display("client %0d read address %h that no earlier write covered", c, a);
        end else if (rdata[c] !== ref_mem[int'(a)]) begin
          err_cnt++;
          $display("mismatch rdata_o[%0d] at address %h: got %h, expected %h",
                   c, a, rdata[c], ref_mem[int'(a)]);
        end
        valids++;
      end
      acked = ack[c];
    end
    if (takes != (t_write[t] ? words : 0)) begin
      err_cnt++;
      $display("mismatch wdata_take_o[%0d] pulses: got %h, expected %h",
               c, takes, t_write[t] ? words : 0);
    end
    if (valids != (t_write[t] ? 0 : words)) begin
      err_cnt++;
      $display("mismatch rdata_valid_o[%0d] pulses: got %h, expected %h",
               c, valids, t_write[t] ? 0 : words);
    end
    check_bit("CA direction", model_ca_write, t_write[t]);
    if (model_ca_addr !== t_addr[t]) begin
      err_cnt++;
      $display("mismatch CA address: got %h, expected %h", model_ca_addr, t_addr[t]);
    end
    if (t_write[t]) begin
      for (int k = 0; k < words; k++) begin
        ref_mem[int'(t_addr[t] + ADDR_W'(k))] = t_base[t] + hyper_word_t'(k);
      end
    end
    order_q.push_back(c);
    req[c] <= 1'b0;
    repeat (2) @(posedge clk);
    if (ack[c]) begin
      err_cnt++;
      $display("ack_o[%0d] stayed high more than one cycle after req_i fell", c);
    end
  endtask

  // Strobes and ack rises only toward a client with a request
  always @(posedge clk) begin
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      if ((wdata_take[c] || rdata_valid[c]) && !req[c]) begin
        mon_err_cnt++;
        $display("data strobe reached client %0d without a request", c);
      end
      if (ack[c] && !ack_prev[c] && !req[c]) begin
        mon_err_cnt++;
        $display("ack_o[%0d] rose without req_i", c);
      end
    end
    ack_prev <= ack;
  end

  initial begin
    int i;
    int g;
    int c0;
    int c1;
    req         <= '0;
    cmd         <= '0;
    wdata       <= '0;
    err_cnt     = 0;
    mon_err_cnt = 0;
    // Arbiter starts its search after the last client
    last_served = NUM_CLIENTS - 1;
    load_list();
    list_loaded = 1'b1;
    // Flops take their reset values from the first clock edge on
    repeat (2) @(posedge clk);
    repeat (4) begin
      @(posedge clk);
      check_idle_pins();
      check_bit("hyper_reset_n_o", dev_reset_n, 1'b0);
    end
    wait (arst_n);
    repeat (2) @(posedge clk);
    check_idle_pins();
    check_bit("hyper_reset_n_o", dev_reset_n, 1'b1);

    i = 0;
    while (i < t_group.size()) begin
      g  = t_group[i];
      c0 = -1;
      c1 = -1;
      while (i < t_group.size() && t_group[i] == g) begin
        if (t_client[i] == 0) c0 = i;
        else c1 = i;
        i++;
      end
      order_q.delete();
      fork
        begin
          if (c0 >= 0) run_txn(0, c0);
        end
        begin
          if (c1 >= 0) run_txn(1, c1);
        end
      join
      if (c0 >= 0 && c1 >= 0 && order_q[0] != (last_served + 1) % NUM_CLIENTS) begin
        err_cnt++;
        $display("group %0h was served out of round-robin order, client %0d first",
                 g, order_q[0]);
      end
      if (order_q.size() > 0) last_served = order_q[order_q.size() - 1];
    end

    $display("errors: %0d checks, %0d protocol monitor, %0d memory model",
             err_cnt, mon_err_cnt, model_err_cnt);
    if (err_cnt + mon_err_cnt + model_err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the number of transactions
  initial begin
    wait (list_loaded);
    #((t_group.size() * TXN_CYCLES + 100) * CLK_NS);
    $display("timeout: the run did not finish within the watchdog limit");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tb_clkgen.sv
// Testbench clock and reset source, 4 ns clock with reset held for 8 cycles
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/hyper_ram_model.sv
// Behavioral HyperRAM for simulation, decodes the CA bytes and serves linear bursts at fixed latency
`default_nettype none

module hyper_ram_model (
  input  wire                        clk_i,
  input  wire                        reset_n_i,
  input  wire                        cs_n_i,
  inout  wire  [hyper_pkg::DQ_W-1:0] dq_io,
  input  wire                        rwds_i,
  // Controller output enables, used to check the chip-select window
  input  wire                        dq_oe_i,
  input  wire                        rwds_oe_i,
  // Last decoded command
  output logic                       ca_write_o,
  output logic [hyper_pkg::ADDR_W-1:0] ca_addr_o,
  output int                         err_cnt_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import hyper_pkg::*;

  hyper_word_t       mem [int];
  logic [CA_W-1:0]   ca_sr;
  logic              is_write;
  logic [ADDR_W-1:0] base_addr;
  logic [ADDR_W-1:0] a;
  logic [DQ_W-1:0]   hi_byte;
  hyper_word_t       rd_word;
  int                beat_n = 0;
  int                k_now;
  int                d;
  int                errs = 0;
  logic              drv_en = 1'b0;
  logic [DQ_W-1:0]   drv_val = '0;

  // Unwritten words return a pattern built from the full address
  function automatic hyper_word_t read_word(input logic [ADDR_W-1:0] addr);
    if (mem.exists(int'(addr))) begin
      return mem[int'(addr)];
    end
    return addr[15:0] ^ {addr[23:16], addr[23:16]};
  endfunction

  assign dq_io     = drv_en ? drv_val : 'z;
  assign err_cnt_o = errs;

  always @(posedge clk_i) begin
    if (reset_n_i !== 1'b1) begin
      // Device held in reset ignores the bus
      beat_n <= 0;
      drv_en <= 1'b0;
    end else if (cs_n_i) begin
      beat_n <= 0;
      drv_en <= 1'b0;
      if (dq_oe_i || rwds_oe_i) begin
        errs++;
        $display("model error: controller drives the bus while chip select is high");
      end
    end else begin
      k_now = beat_n + 1;
      beat_n <= k_now;
      // CA bytes, most significant first
      if (k_now <= CA_BYTES) begin
        if (!dq_oe_i) begin
          errs++;
          $display("model error: CA byte %0d was not driven", k_now);
        end
        ca_sr = {ca_sr[CA_W-DQ_W-1:0], dq_io};
        if (k_now == CA_BYTES) begin
          is_write  = !ca_sr[CA_RW_BIT];
          base_addr = {ca_sr[CA_UPPER_LSB +: ADDR_W-CA_LOWER_W], ca_sr[CA_LOWER_W-1:0]};
          if (!ca_sr[CA_LINEAR_BIT]) begin
            errs++;
            $display("model error: linear burst bit is not set in the CA word");
          end
          if (ca_sr[46] || ca_sr[44:37] != '0) begin
            errs++;
            $display("model error: CA word selects register space or sets unused address bits");
          end
          ca_write_o <= is_write;
          ca_addr_o  <= base_addr;
        end
      end
      // Data beats start right after the fixed latency
      d = k_now - (CA_BYTES + LAT_CYCLES);
      if (!is_write && d >= 0) begin
        if (dq_oe_i) begin
          errs++;
          $display("model error: controller drives DQ during a read data beat");
        end
        a       = base_addr + ADDR_W'(d / 2);
        rd_word = read_word(a);
        drv_en  <= 1'b1;
        drv_val <= (d % 2 == 0) ? rd_word[15:8] : rd_word[7:0];
      end
      if (is_write && d >= 1) begin
        if (!dq_oe_i || !rwds_oe_i || rwds_i) begin
          errs++;
          $display("model error: write beat without DQ driven or with RWDS not held low");
        end
        a = base_addr + ADDR_W'((d - 1) / 2);
        if ((d - 1) % 2 == 0) begin
          hi_byte = dq_io;
        end else begin
          mem[int'(a)] = {hi_byte, dq_io};
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/hyper_ctrl_top.sv
// HyperRAM controller top, two client ports share one HyperBus PHY through the arbiter
`default_nettype none

module hyper_ctrl_top (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  // Client ports, indexed by client
  input  logic [hyper_pkg::NUM_CLIENTS-1:0]                  req_i,
  input  hyper_pkg::hyper_cmd_t [hyper_pkg::NUM_CLIENTS-1:0]  cmd_i,
  output logic [hyper_pkg::NUM_CLIENTS-1:0]                  ack_o,
  input  hyper_pkg::hyper_word_t [hyper_pkg::NUM_CLIENTS-1:0] wdata_i,
  output logic [hyper_pkg::NUM_CLIENTS-1:0]                  wdata_take_o,
  output hyper_pkg::hyper_word_t [hyper_pkg::NUM_CLIENTS-1:0] rdata_o,
  output logic [hyper_pkg::NUM_CLIENTS-1:0]                  rdata_valid_o,
  // HyperBus pins
  output logic                                               hyper_cs_n_o,
  output logic                                               hyper_ck_o,
  output logic                                               hyper_ck_n_o,
  output logic                                               hyper_rwds_o,
  output logic                                               hyper_rwds_oe_o,
  input  logic                                               hyper_rwds_i,
  output logic [hyper_pkg::DQ_W-1:0]                         hyper_dq_o,
  output logic                                               hyper_dq_oe_o,
  input  logic [hyper_pkg::DQ_W-1:0]                         hyper_dq_i,
  output logic                                               hyper_reset_n_o
);
  import hyper_pkg::*;

  // Arbiter to PHY
  logic        cmd_valid;
  hyper_cmd_t  cmd;
  logic        done;
  hyper_word_t wdata;
  logic        wdata_take;
  hyper_word_t rdata;
  logic        rdata_valid;

  hyper_arbiter i_arbiter (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .req_i         (req_i),
    .cmd_i         (cmd_i),
    .ack_o         (ack_o),
    .wdata_i       (wdata_i),
    .wdata_take_o  (wdata_take_o),
    .rdata_o       (rdata_o),
    .rdata_valid_o (rdata_valid_o),
    .cmd_valid_o   (cmd_valid),
    .cmd_o         (cmd),
    .done_i        (done),
    .wdata_o       (wdata),
    .wdata_take_i  (wdata_take),
    .rdata_i       (rdata),
    .rdata_valid_i (rdata_valid)
  );

  hyper_phy i_phy (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .cmd_valid_i     (cmd_valid),
    .cmd_i           (cmd),
    .done_o          (done),
    .wdata_i         (wdata),
    .wdata_take_o    (wdata_take),
    .rdata_o         (rdata),
    .rdata_valid_o   (rdata_valid),
    .hyper_cs_n_o    (hyper_cs_n_o),
    .hyper_ck_o      (hyper_ck_o),
    .hyper_ck_n_o    (hyper_ck_n_o),
    .hyper_rwds_o    (hyper_rwds_o),
    .hyper_rwds_oe_o (hyper_rwds_oe_o),
    .hyper_rwds_i    (hyper_rwds_i),
    .hyper_dq_o      (hyper_dq_o),
    .hyper_dq_oe_o   (hyper_dq_oe_o),
    .hyper_dq_i      (hyper_dq_i),
    .hyper_reset_n_o (hyper_reset_n_o)
  );

endmodule

`default_nettype wire

// File: hdl/hyper_phy.sv
// HyperBus sequencer for one granted command, drives CA, fixed latency and DDR data beats
`default_nettype none

module hyper_phy (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  // Command from the arbiter
  input  logic                           cmd_valid_i,
  input  hyper_pkg::hyper_cmd_t          cmd_i,
  output logic                           done_o,
  // Data beats
  input  hyper_pkg::hyper_word_t         wdata_i,
  output logic                           wdata_take_o,
  output hyper_pkg::hyper_word_t         rdata_o,
  output logic                           rdata_valid_o,
  // HyperBus pins
  output logic                           hyper_cs_n_o,
  output logic                           hyper_ck_o,
  output logic                           hyper_ck_n_o,
  output logic                           hyper_rwds_o,
  output logic                           hyper_rwds_oe_o,
  input  logic                           hyper_rwds_i,
  output logic [hyper_pkg::DQ_W-1:0]     hyper_dq_o,
  output logic                           hyper_dq_oe_o,
  input  logic [hyper_pkg::DQ_W-1:0]     hyper_dq_i,
  output logic                           hyper_reset_n_o
);
  import hyper_pkg::*;

  typedef enum logic [2:0] {
    s_idle,
    s_ca,
    s_lat,
    s_data,
    s_recov
  } state_e;

  state_e              state_q;
  logic [PHASE_W-1:0]  phase_q;
  // Words finished in the current burst
  logic [BURST_W-1:0]  word_q;
  // Low for the high byte of a word, high for the low byte
  logic                byte_q;

  logic                cs_n_q;
  logic                ck_q;
  logic                dq_oe_q;
  logic                rwds_oe_q;
  logic                done_q;
  logic                reset_n_q;

  // Byte lane and CA shift register
  logic [CA_W-1:0]     ca_word;
  logic [CA_W-1:0]     ca_q;
  logic [DQ_W-1:0]     dq_q;
  logic [DQ_W-1:0]     rd_hi_q;

  logic                ca_last;
  logic                lat_last;
  logic                last_word;
  logic                in_data;

  // CA word from the command fields, memory space and linear burst
  always_comb begin
    ca_word                 = '0;
    ca_word[CA_RW_BIT]      = !cmd_i.write;
    ca_word[CA_LINEAR_BIT]  = 1'b1;
    ca_word[CA_UPPER_LSB +: ADDR_W-CA_LOWER_W] = cmd_i.addr[ADDR_W-1:CA_LOWER_W];
    ca_word[CA_LOWER_W-1:0] = cmd_i.addr[CA_LOWER_W-1:0];
  end

  assign ca_last   = (phase_q == PHASE_W'(CA_BYTES - 1));
  assign lat_last  = (phase_q == PHASE_W'(LAT_CYCLES - 1));
  // Burst field of 0 wraps to 63, which gives 64 words
  assign last_word = byte_q && (word_q == BURST_W'(cmd_i.burst - 1'b1));
  assign in_data   = (state_q == s_data);

  // Control state
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= s_idle;
      phase_q   <= '0;
      word_q    <= '0;
      byte_q    <= 1'b0;
      cs_n_q    <= 1'b1;
      ck_q      <= 1'b0;
      dq_oe_q   <= 1'b0;
      rwds_oe_q <= 1'b0;
      done_q    <= 1'b0;
      reset_n_q <= 1'b0;
    end else begin
      // Device reset released one cycle after ours
      reset_n_q <= 1'b1;
      case (state_q)
        s_idle: begin
          if (cmd_valid_i) begin
            state_q <= s_ca;
            phase_q <= '0;
            cs_n_q  <= 1'b0;
            dq_oe_q <= 1'b1;
          end
        end
        s_ca: begin
          ck_q    <= ~ck_q;
          phase_q <= phase_q + 1'b1;
          if (ca_last) begin
            state_q <= s_lat;
            phase_q <= '0;
            dq_oe_q <= 1'b0;
          end
        end
        s_lat: begin
          ck_q    <= ~ck_q;
          phase_q <= phase_q + 1'b1;
          if (lat_last) begin
            state_q   <= s_data;
            phase_q   <= '0;
            word_q    <= '0;
            byte_q    <= 1'b0;
            // Master drives DQ and a low RWDS only on writes
            dq_oe_q   <= cmd_i.write;
            rwds_oe_q <= cmd_i.write;
          end
        end
        s_data: begin
          ck_q   <= ~ck_q;
          byte_q <= ~byte_q;
          if (byte_q) begin
            word_q <= word_q + 1'b1;
          end
          if (last_word) begin
            state_q   <= s_recov;
            phase_q   <= '0;
            cs_n_q    <= 1'b1;
            ck_q      <= 1'b0;
            dq_oe_q   <= 1'b0;
            rwds_oe_q <= 1'b0;
            done_q    <= 1'b1;
          end
        end
        s_recov: begin
          // Chip select stays high at least two cycles, done holds until the grant drops
          if (phase_q != '0 && !cmd_valid_i) begin
            state_q <= s_idle;
            done_q  <= 1'b0;
          end else begin
            phase_q <= PHASE_W'(1);
          end
        end
        default: begin
          state_q <= s_idle;
        end
      endcase
    end
  end

  // Byte lane and read capture
  always_ff @(posedge clk_i) begin
    case (state_q)
      s_idle: begin
        dq_q <= ca_word[CA_W-1 -: DQ_W];
        ca_q <= ca_word << DQ_W;
      end
      s_ca: begin
        dq_q <= ca_q[CA_W-1 -: DQ_W];
        ca_q <= ca_q << DQ_W;
      end
      s_lat: begin
        // High byte of the first word goes out on the first data cycle
        dq_q <= wdata_i[DQ_W +: DQ_W];
      end
      s_data: begin
        if (!byte_q) begin
          // Word is still current at the edge that ends its take cycle
          dq_q    <= wdata_i[DQ_W-1:0];
          rd_hi_q <= hyper_dq_i;
        end else begin
          dq_q <= wdata_i[DQ_W +: DQ_W];
        end
      end
      default: begin
        dq_q <= dq_q;
      end
    endcase
  end

  // One take per written word, on its high byte cycle
  assign wdata_take_o  = in_data && cmd_i.write && !byte_q;
  // Read word completes with the low byte on the pins
  assign rdata_valid_o = in_data && !cmd_i.write && byte_q;
  assign rdata_o       = {rd_hi_q, hyper_dq_i};

  assign done_o          = done_q;
  assign hyper_cs_n_o    = cs_n_q;
  assign hyper_ck_o      = ck_q;
  assign hyper_ck_n_o    = ~ck_q;
  assign hyper_dq_o      = dq_q;
  assign hyper_dq_oe_o   = dq_oe_q;
  assign hyper_reset_n_o = reset_n_q;

  // Full-word writes only, so RWDS is held low whenever driven
  assign hyper_rwds_o    = 1'b0;
  assign hyper_rwds_oe_o = rwds_oe_q;

endmodule

`default_nettype wire

// File: hdl/hyper_arbiter.sv
// Round-robin arbiter that grants one client at a time to the HyperBus PHY with four-phase acks
`default_nettype none

module hyper_arbiter (
  input  logic                                              clk_i,
  input  logic                                              arst_n_i,
  // Client side
  input  logic [hyper_pkg::NUM_CLIENTS-1:0]                 req_i,
  input  hyper_pkg::hyper_cmd_t [hyper_pkg::NUM_CLIENTS-1:0] cmd_i,
  output logic [hyper_pkg::NUM_CLIENTS-1:0]                 ack_o,
  input  hyper_pkg::hyper_word_t [hyper_pkg::NUM_CLIENTS-1:0] wdata_i,
  output logic [hyper_pkg::NUM_CLIENTS-1:0]                 wdata_take_o,
  output hyper_pkg::hyper_word_t [hyper_pkg::NUM_CLIENTS-1:0] rdata_o,
  output logic [hyper_pkg::NUM_CLIENTS-1:0]                 rdata_valid_o,
  // PHY side
  output logic                                              cmd_valid_o,
  output hyper_pkg::hyper_cmd_t                             cmd_o,
  input  logic                                              done_i,
  output hyper_pkg::hyper_word_t                            wdata_o,
  input  logic                                              wdata_take_i,
  input  hyper_pkg::hyper_word_t                            rdata_i,
  input  logic                                              rdata_valid_i
);
  import hyper_pkg::*;

  // One-hot grant, all zero while idle
  logic [NUM_CLIENTS-1:0] grant_q;
  logic [NUM_CLIENTS-1:0] ack_q;
  // Last client served, start of the round-robin search
  logic [CLIENT_W-1:0]    last_q;
  logic [CLIENT_W-1:0]    next_idx;
  logic                   found;
  logic                   release_grant;

  // Search from the client after the last one served
  always_comb begin
    next_idx = last_q;
    found    = 1'b0;
    for (int k = 1; k <= NUM_CLIENTS; k++) begin
      if (!found && req_i[(int'(last_q) + k) % NUM_CLIENTS]) begin
        next_idx = CLIENT_W'((int'(last_q) + k) % NUM_CLIENTS);
        found    = 1'b1;
      end
    end
  end

  // Acknowledged client has dropped its request
  assign release_grant = |(ack_q & ~req_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      grant_q <= '0;
      ack_q   <= '0;
      last_q  <= CLIENT_W'(NUM_CLIENTS - 1);
    end else if (grant_q == '0) begin
      // New grant only once the PHY has left its done state
      if (found && !done_i) begin
        grant_q <= NUM_CLIENTS'(1) << next_idx;
        last_q  <= next_idx;
      end
    end else if (release_grant) begin
      grant_q <= '0;
      ack_q   <= '0;
    end else if (done_i) begin
      ack_q <= grant_q;
    end
  end

  assign ack_o       = ack_q;
  assign cmd_valid_o = |grant_q;

  // last_q equals the granted client while a grant is held
  assign cmd_o   = cmd_i[last_q];
  assign wdata_o = wdata_i[last_q];

  // Beat strobes and read data reach the granted client only
  always_comb begin
    for (int k = 0; k < NUM_CLIENTS; k++) begin
      wdata_take_o[k]  = grant_q[k] & wdata_take_i;
      rdata_valid_o[k] = grant_q[k] & rdata_valid_i;
      rdata_o[k]       = grant_q[k] ? rdata_i : '0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/hyper_pkg.sv
// Shared constants, command struct and CA field layout, imported by the RTL and the testbench
`default_nettype none

package hyper_pkg;

  // Client count and index width
  localparam int NUM_CLIENTS = 2;
  localparam int CLIENT_W    = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1;

  // Command fields
  localparam int ADDR_W  = 24;
  // Burst field of 0 stands for 64 words
  localparam int BURST_W = 6;

  // Bus widths
  localparam int DQ_W   = 8;
  localparam int WORD_W = 2 * DQ_W;

  // Fixed initial latency in HyperBus clocks and in clk_i cycles
  localparam int LATENCY_CK = 6;
  localparam int LAT_CYCLES = 2 * LATENCY_CK;

  // Command/address phase, one byte per clk_i cycle
  localparam int CA_BYTES = 6;
  localparam int CA_W     = CA_BYTES * DQ_W;

  // Phase counter covers the longest of the CA and latency phases
  localparam int PHASE_W = $clog2(LAT_CYCLES);

  // CA word bit positions
  localparam int CA_RW_BIT     = 47;
  localparam int CA_LINEAR_BIT = 45;
  // Address bits 23..3 start here
  localparam int CA_UPPER_LSB  = 16;
  // Address bits 2..0 sit at the bottom of the CA word
  localparam int CA_LOWER_W    = 3;

  typedef logic [WORD_W-1:0] hyper_word_t;

  // One client request, 31 bits
  typedef struct packed {
    logic               write;
    logic [ADDR_W-1:0]  addr;
    logic [BURST_W-1:0] burst;
  } hyper_cmd_t;

endpackage

`default_nettype wire
